/* hw/lsu_pkg.sv */
// Widths, memory size, operation codes, fault causes and the result word union
package lsu_pkg;

  // ------------------------------
  // Widths and sizes
  // ------------------------------
  localparam int unsigned XLEN         = 32;
  localparam int unsigned TRANS_ID_W   = 3;
  localparam int unsigned MEM_ADDR_W   = 8;
  localparam int unsigned MEM_BYTES    = 1 << MEM_ADDR_W;
  localparam int unsigned BE_W         = XLEN / 8;
  localparam int unsigned TVAL_W       = 16;
  localparam int unsigned CAUSE_W      = 4;
  localparam int unsigned NR_PIPE_REGS = 2;

  // Load and store operations
  typedef enum logic [3:0] {
    LB  = 4'd0,
    LBU = 4'd1,
    LH  = 4'd2,
    LHU = 4'd3,
    LW  = 4'd4,
    SB  = 4'd5,
    SH  = 4'd6,
    SW  = 4'd7
  } lsu_op_e;

  // Exception causes
  localparam logic [CAUSE_W-1:0] CAUSE_LD_MISALIGNED = 4'd4;
  localparam logic [CAUSE_W-1:0] CAUSE_LD_ACCESS     = 4'd5;
  localparam logic [CAUSE_W-1:0] CAUSE_ST_MISALIGNED = 4'd6;
  localparam logic [CAUSE_W-1:0] CAUSE_ST_ACCESS     = 4'd7;

  // Result word, read through the view picked by the bundle fault flag
  typedef union packed {
    logic [XLEN-1:0] data;
    struct packed {
      logic [CAUSE_W-1:0]               cause;
      logic [XLEN-CAUSE_W-TVAL_W-1:0]   rsvd;
      logic [TVAL_W-1:0]                tval;
    } fault;
  } lsu_word_u;

  function automatic logic lsu_is_store(lsu_op_e op);
    return (op == SB) || (op == SH) || (op == SW);
  endfunction

endpackage

/* hw/lsu_result_if.sv */
// Result bundle interface between the memory stage, the pipeline stages and the splitter
`timescale 1ns/1ps

interface lsu_result_if
  import lsu_pkg::*;
();

  logic                  valid;
  logic [TRANS_ID_W-1:0] trans_id;
  logic                  is_store;
  logic                  fault;
  lsu_word_u             word;

  // Producer side
  modport src (output valid, output trans_id, output is_store, output fault, output word);

  // Consumer side
  modport dst (input valid, input trans_id, input is_store, input fault, input word);

endinterface

/* hw/lsu_agu.sv */
// Address generation unit with byte enables, fault detection and the request register
`timescale 1ns/1ps

module lsu_agu
  import lsu_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  valid_i,
  input  lsu_op_e               op_i,
  input  logic [XLEN-1:0]       operand_a_i,
  input  logic [XLEN-1:0]       imm_i,
  input  logic [XLEN-1:0]       operand_b_i,
  input  logic [TRANS_ID_W-1:0] trans_id_i,
  output logic                  req_valid_o,
  output lsu_op_e               req_op_o,
  output logic [XLEN-1:0]       req_addr_o,
  output logic [XLEN-1:0]       req_wdata_o,
  output logic [BE_W-1:0]       req_be_o,
  output logic [TRANS_ID_W-1:0] req_trans_id_o,
  output logic                  req_fault_o,
  output logic [CAUSE_W-1:0]    req_cause_o
);

  logic [XLEN-1:0]    addr;
  logic               is_store;
  logic               misaligned;
  logic               out_of_range;
  logic [BE_W-1:0]    be;
  logic [CAUSE_W-1:0] cause;

  // Signed base plus immediate
  assign addr     = $unsigned($signed(operand_a_i) + $signed(imm_i));
  assign is_store = lsu_is_store(op_i);

  // Anything above the byte memory is an access fault
  assign out_of_range = |addr[XLEN-1:MEM_ADDR_W];

  // ------------------------------
  // Byte enables and alignment
  // ------------------------------
  always_comb begin
    be         = '0;
    misaligned = 1'b0;
    case (op_i)
      LB, LBU, SB: begin
        be = 4'b0001 << addr[1:0];
      end
      LH, LHU, SH: begin
        be         = 4'b0011 << addr[1:0];
        misaligned = addr[0];
      end
      LW, SW: begin
        be         = 4'b1111;
        misaligned = |addr[1:0];
      end
      default: ;
    endcase
  end

  // Access fault wins over misalignment
  always_comb begin
    cause = '0;
    if (out_of_range) begin
      cause = is_store ? CAUSE_ST_ACCESS : CAUSE_LD_ACCESS;
    end else if (misaligned) begin
      cause = is_store ? CAUSE_ST_MISALIGNED : CAUSE_LD_MISALIGNED;
    end
  end

  // ------------------------------
  // Request register
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_valid_o <= 1'b0;
    end else begin
      req_valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      req_op_o       <= op_i;
      req_addr_o     <= addr;
      // Store data moved onto its byte lanes
      req_wdata_o    <= operand_b_i << {addr[1:0], 3'b000};
      req_be_o       <= be;
      req_trans_id_o <= trans_id_i;
      req_fault_o    <= out_of_range | misaligned;
      req_cause_o    <= cause;
    end
  end

endmodule

/* hw/lsu_mem_access.sv */
// Memory stage with bare translation, byte memory, load extension and store write
`timescale 1ns/1ps

module lsu_mem_access
  import lsu_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  req_valid_i,
  input  lsu_op_e               req_op_i,
  input  logic [XLEN-1:0]       req_addr_i,
  input  logic [XLEN-1:0]       req_wdata_i,
  input  logic [BE_W-1:0]       req_be_i,
  input  logic [TRANS_ID_W-1:0] req_trans_id_i,
  input  logic                  req_fault_i,
  input  logic [CAUSE_W-1:0]    req_cause_i,
  lsu_result_if.src             res
);

  logic [7:0]            mem [MEM_BYTES];
  logic [MEM_ADDR_W-1:0] word_base;
  logic                  is_store;
  logic                  do_store;
  logic [XLEN-1:0]       rword;
  logic [XLEN-1:0]       rshift;
  logic [XLEN-1:0]       ext;
  lsu_word_u             word;

  // Bare mode, physical address is the low address bits
  assign word_base = {req_addr_i[MEM_ADDR_W-1:2], 2'b00};
  assign is_store  = lsu_is_store(req_op_i);
  assign do_store  = req_valid_i && !req_fault_i && is_store;

  // ------------------------------
  // Store write
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (do_store) begin
      for (int i = 0; i < BE_W; i++) begin
        if (req_be_i[i]) begin
          mem[word_base + MEM_ADDR_W'(i)] <= req_wdata_i[8*i +: 8];
        end
      end
    end
  end

  // ------------------------------
  // Load read and extension
  // ------------------------------
  always_comb begin
    for (int i = 0; i < BE_W; i++) begin
      rword[8*i +: 8] = mem[word_base + MEM_ADDR_W'(i)];
    end
  end

  // Addressed byte or halfword down to bit 0
  assign rshift = rword >> {req_addr_i[1:0], 3'b000};

  always_comb begin
    case (req_op_i)
      LB:      ext = {{(XLEN-8){rshift[7]}}, rshift[7:0]};
      LBU:     ext = {{(XLEN-8){1'b0}}, rshift[7:0]};
      LH:      ext = {{(XLEN-16){rshift[15]}}, rshift[15:0]};
      LHU:     ext = {{(XLEN-16){1'b0}}, rshift[15:0]};
      default: ext = rshift;
    endcase
  end

  // Fault view, load data, or zero for a store
  always_comb begin
    word = '0;
    if (req_fault_i) begin
      word.fault.cause = req_cause_i;
      word.fault.rsvd  = '0;
      word.fault.tval  = req_addr_i[TVAL_W-1:0];
    end else if (!is_store) begin
      word.data = ext;
    end
  end

  // ------------------------------
  // Result bundle register
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      res.valid <= 1'b0;
    end else begin
      res.valid <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      res.trans_id <= req_trans_id_i;
      res.is_store <= is_store;
      res.fault    <= req_fault_i;
      res.word     <= word;
    end
  end

endmodule

/* hw/lsu_pipe_stage.sv */
// One output pipeline register for a result bundle
`timescale 1ns/1ps

module lsu_pipe_stage
  import lsu_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  lsu_result_if.dst in,
  lsu_result_if.src out
);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out.valid <= 1'b0;
    end else begin
      out.valid <= in.valid;
    end
  end

  // Payload only moves with a valid bundle
  always_ff @(posedge clk_i) begin
    if (in.valid) begin
      out.trans_id <= in.trans_id;
      out.is_store <= in.is_store;
      out.fault    <= in.fault;
      out.word     <= lsu_word_u'(in.word);
    end
  end

endmodule

/* hw/lsu_result_split.sv */
// Result splitter onto the load and store output ports
`timescale 1ns/1ps

module lsu_result_split
  import lsu_pkg::*;
(
  lsu_result_if.dst             in,
  output logic                  load_valid_o,
  output logic [TRANS_ID_W-1:0] load_trans_id_o,
  output logic [XLEN-1:0]       load_result_o,
  output logic                  load_ex_valid_o,
  output logic [CAUSE_W-1:0]    load_ex_cause_o,
  output logic [TVAL_W-1:0]     load_ex_tval_o,
  output logic                  store_valid_o,
  output logic [TRANS_ID_W-1:0] store_trans_id_o,
  output logic                  store_ex_valid_o,
  output logic [CAUSE_W-1:0]    store_ex_cause_o,
  output logic [TVAL_W-1:0]     store_ex_tval_o
);

  always_comb begin
    load_valid_o     = 1'b0;
    load_trans_id_o  = '0;
    load_result_o    = '0;
    load_ex_valid_o  = 1'b0;
    load_ex_cause_o  = '0;
    load_ex_tval_o   = '0;
    store_valid_o    = 1'b0;
    store_trans_id_o = '0;
    store_ex_valid_o = 1'b0;
    store_ex_cause_o = '0;
    store_ex_tval_o  = '0;

    if (in.valid && in.is_store) begin
      store_valid_o    = 1'b1;
      store_trans_id_o = in.trans_id;
      if (in.fault) begin
        store_ex_valid_o = 1'b1;
        store_ex_cause_o = in.word.fault.cause;
        store_ex_tval_o  = in.word.fault.tval;
      end
    end else if (in.valid) begin
      load_valid_o    = 1'b1;
      load_trans_id_o = in.trans_id;
      // Fault view carries cause and tval, data view the loaded value
      if (in.fault) begin
        load_ex_valid_o = 1'b1;
        load_ex_cause_o = in.word.fault.cause;
        load_ex_tval_o  = in.word.fault.tval;
      end else begin
        load_result_o = in.word.data;
      end
    end
  end

endmodule

/* hw/lsu_top.sv */
// Load/store unit top level with AGU, memory stage, output pipeline and result splitter
`timescale 1ns/1ps

module lsu_top
  import lsu_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  valid_i,
  input  lsu_op_e               op_i,
  input  logic [XLEN-1:0]       operand_a_i,
  input  logic [XLEN-1:0]       imm_i,
  input  logic [XLEN-1:0]       operand_b_i,
  input  logic [TRANS_ID_W-1:0] trans_id_i,
  output logic                  load_valid_o,
  output logic [TRANS_ID_W-1:0] load_trans_id_o,
  output logic [XLEN-1:0]       load_result_o,
  output logic                  load_ex_valid_o,
  output logic [CAUSE_W-1:0]    load_ex_cause_o,
  output logic [TVAL_W-1:0]     load_ex_tval_o,
  output logic                  store_valid_o,
  output logic [TRANS_ID_W-1:0] store_trans_id_o,
  output logic                  store_ex_valid_o,
  output logic [CAUSE_W-1:0]    store_ex_cause_o,
  output logic [TVAL_W-1:0]     store_ex_tval_o
);

  logic                  req_valid;
  lsu_op_e               req_op;
  logic [XLEN-1:0]       req_addr;
  logic [XLEN-1:0]       req_wdata;
  logic [BE_W-1:0]       req_be;
  logic [TRANS_ID_W-1:0] req_trans_id;
  logic                  req_fault;
  logic [CAUSE_W-1:0]    req_cause;

  // Bundle chain, entry 0 from the memory stage
  lsu_result_if res_if [NR_PIPE_REGS+1] ();

  lsu_agu lsu_agu_inst (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .valid_i        (valid_i),
    .op_i           (op_i),
    .operand_a_i    (operand_a_i),
    .imm_i          (imm_i),
    .operand_b_i    (operand_b_i),
    .trans_id_i     (trans_id_i),
    .req_valid_o    (req_valid),
    .req_op_o       (req_op),
    .req_addr_o     (req_addr),
    .req_wdata_o    (req_wdata),
    .req_be_o       (req_be),
    .req_trans_id_o (req_trans_id),
    .req_fault_o    (req_fault),
    .req_cause_o    (req_cause)
  );

  lsu_mem_access lsu_mem_access_inst (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_valid_i    (req_valid),
    .req_op_i       (req_op),
    .req_addr_i     (req_addr),
    .req_wdata_i    (req_wdata),
    .req_be_i       (req_be),
    .req_trans_id_i (req_trans_id),
    .req_fault_i    (req_fault),
    .req_cause_i    (req_cause),
    .res            (res_if[0])
  );

  // ------------------------------
  // Output pipeline
  // ------------------------------
  for (genvar i = 0; i < NR_PIPE_REGS; i++) begin : gen_pipe
    lsu_pipe_stage lsu_pipe_stage_inst (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .in      (res_if[i]),
      .out     (res_if[i+1])
    );
  end

  lsu_result_split lsu_result_split_inst (
    .in               (res_if[NR_PIPE_REGS]),
    .load_valid_o     (load_valid_o),
    .load_trans_id_o  (load_trans_id_o),
    .load_result_o    (load_result_o),
    .load_ex_valid_o  (load_ex_valid_o),
    .load_ex_cause_o  (load_ex_cause_o),
    .load_ex_tval_o   (load_ex_tval_o),
    .store_valid_o    (store_valid_o),
    .store_trans_id_o (store_trans_id_o),
    .store_ex_valid_o (store_ex_valid_o),
    .store_ex_cause_o (store_ex_cause_o),
    .store_ex_tval_o  (store_ex_tval_o)
  );

endmodule

/* verif/lsu_assert.sv */
// Concurrent assertions on the load and store result ports, bound to the top level
`timescale 1ns/1ps

module lsu_assert
  import lsu_pkg::*;
(
  input logic               clk_i,
  input logic               rst_n_i,
  input logic               load_valid_i,
  input logic               load_ex_valid_i,
  input logic [CAUSE_W-1:0] load_ex_cause_i,
  input logic               store_valid_i,
  input logic               store_ex_valid_i,
  input logic [CAUSE_W-1:0] store_ex_cause_i
);

  // Number of failed assertions
  int unsigned fail_count = 0;

  // One result port per cycle
  one_port_at_a_time: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(load_valid_i && store_valid_i))
    else begin
      $error("Load and store results valid in the same cycle");
      fail_count++;
    end

  // ------------------------------
  // Exception consistency
  // ------------------------------
  load_ex_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    load_ex_valid_i |-> load_valid_i)
    else begin
      $error("Load exception without a load result");
      fail_count++;
    end

  store_ex_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    store_ex_valid_i |-> store_valid_i)
    else begin
      $error("Store exception without a store result");
      fail_count++;
    end

  load_ex_cause_ok: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    load_ex_valid_i |-> (load_ex_cause_i == CAUSE_LD_MISALIGNED ||
                         load_ex_cause_i == CAUSE_LD_ACCESS))
    else begin
      $error("Load exception carries a non-load cause");
      fail_count++;
    end

  store_ex_cause_ok: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    store_ex_valid_i |-> (store_ex_cause_i == CAUSE_ST_MISALIGNED ||
                          store_ex_cause_i == CAUSE_ST_ACCESS))
    else begin
      $error("Store exception carries a non-store cause");
      fail_count++;
    end

endmodule

bind lsu_top lsu_assert lsu_assert_inst (
  .clk_i            (clk_i),
  .rst_n_i          (rst_n_i),
  .load_valid_i     (load_valid_o),
  .load_ex_valid_i  (load_ex_valid_o),
  .load_ex_cause_i  (load_ex_cause_o),
  .store_valid_i    (store_valid_o),
  .store_ex_valid_i (store_ex_valid_o),
  .store_ex_cause_i (store_ex_cause_o)
);

/* verif/lsu_tb.sv */
// Testbench for the load/store unit with file stimulus, in-order result checks and watchdog
`timescale 1ns/1ps

module lsu_tb
  import lsu_pkg::*;
();

  logic                  clk_i   = 1'b0;
  logic                  rst_n_i = 1'b0;
  logic                  valid_i;
  lsu_op_e               op_i;
  logic [XLEN-1:0]       operand_a_i;
  logic [XLEN-1:0]       imm_i;
  logic [XLEN-1:0]       operand_b_i;
  logic [TRANS_ID_W-1:0] trans_id_i;
  logic                  load_valid_o;
  logic [TRANS_ID_W-1:0] load_trans_id_o;
  logic [XLEN-1:0]       load_result_o;
  logic                  load_ex_valid_o;
  logic [CAUSE_W-1:0]    load_ex_cause_o;
  logic [TVAL_W-1:0]     load_ex_tval_o;
  logic                  store_valid_o;
  logic [TRANS_ID_W-1:0] store_trans_id_o;
  logic                  store_ex_valid_o;
  logic [CAUSE_W-1:0]    store_ex_cause_o;
  logic [TVAL_W-1:0]     store_ex_tval_o;

  // Stimulus lines and outstanding expectations
  logic [31:0] stim_op[$];
  logic [31:0] stim_a[$];
  logic [31:0] stim_imm[$];
  logic [31:0] stim_b[$];
  logic [31:0] stim_tid[$];
  logic [31:0] stim_kind[$];
  logic [31:0] stim_exp[$];
  logic [31:0] stim_gap[$];
  logic [31:0] exp_kind_q[$];
  logic [31:0] exp_tid_q[$];
  logic [31:0] exp_word_q[$];
  int          n_ops       = 0;
  int          n_checked   = 0;
  int          error_count = 0;
  bit          stim_loaded = 1'b0;

  lsu_top lsu_top_inst (.*);

  initial begin : clock_gen
    forever #5 clk_i = ~clk_i;
  end

  task automatic report_value(input string name, input logic [31:0] expv,
                              input logic [31:0] got);
    error_count++;
    $display("[ERROR] %s: expected 0x%h, got 0x%h", name, expv, got);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic report_failure(input string why);
    error_count++;
    $display("[ERROR] %s", why);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] expv, input logic [31:0] got);
    assert (got === expv) else report_value(name, expv, got);
  endtask

  // ------------------------------
  // Result comparison
  // ------------------------------
  task automatic check_result(input logic [31:0] kind, input logic [31:0] tid,
                              input logic [31:0] word);
    if (kind == 0 || kind == 2) begin
      check_eq("load_valid_o", 1, load_valid_o);
      check_eq("load_trans_id_o", tid, load_trans_id_o);
      check_eq("load_ex_valid_o", (kind == 2), load_ex_valid_o);
      if (kind == 0) begin
        check_eq("load_result_o", word, load_result_o);
      end else begin
        check_eq("load_ex_cause_o", word[31:28], load_ex_cause_o);
        check_eq("load_ex_tval_o", word[15:0], load_ex_tval_o);
      end
    end else begin
      check_eq("store_valid_o", 1, store_valid_o);
      check_eq("store_trans_id_o", tid, store_trans_id_o);
      check_eq("store_ex_valid_o", (kind == 3), store_ex_valid_o);
      if (kind == 3) begin
        check_eq("store_ex_cause_o", word[31:28], store_ex_cause_o);
        check_eq("store_ex_tval_o", word[15:0], store_ex_tval_o);
      end
    end
  endtask

  // Outputs settle after the rising edge, so look at them on the falling edge
  always @(negedge clk_i) begin : check_outputs
    assert (lsu_top_inst.lsu_assert_inst.fail_count == 0)
      else report_failure("A concurrent assertion on the result ports failed");
    if (!rst_n_i) begin
      assert (!load_valid_o && !store_valid_o)
        else report_failure("A result valid was high during reset");
    end else if (load_valid_o || store_valid_o) begin
      assert (!(load_valid_o && store_valid_o))
        else report_failure("Load and store results appeared in the same cycle");
      assert (exp_kind_q.size() > 0)
        else report_failure("A result appeared with no operation outstanding");
      check_result(exp_kind_q.pop_front(), exp_tid_q.pop_front(), exp_word_q.pop_front());
      n_checked++;
    end
  end

  // ------------------------------
  // Watchdog
  // ------------------------------
  initial begin : watchdog
    wait (stim_loaded);
    #((n_ops + 10) * (2 + NR_PIPE_REGS) * 10);
    report_failure("Timeout while waiting for results to arrive");
  end

  task automatic read_stim();
    int          fd;
    int          cnt;
    string       line;
    logic [31:0] f[8];
    fd = $fopen("verif/lsu_stim.txt", "r");
    if (fd == 0) begin
      report_failure("Could not open the stimulus file verif/lsu_stim.txt");
    end
    while ($fgets(line, fd)) begin
      if (line.len() > 1 && line.getc(0) != "#") begin
        cnt = $sscanf(line, "%h %h %h %h %h %h %h %h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
        if (cnt == 8) begin
          stim_op.push_back(f[0]);
          stim_a.push_back(f[1]);
          stim_imm.push_back(f[2]);
          stim_b.push_back(f[3]);
          stim_tid.push_back(f[4]);
          stim_kind.push_back(f[5]);
          stim_exp.push_back(f[6]);
          stim_gap.push_back(f[7]);
        end
      end
    end
    $fclose(fd);
    n_ops = stim_op.size();
  endtask

  // ------------------------------
  // Main stimulus
  // ------------------------------
  initial begin : drive_stim
    valid_i     = 1'b0;
    op_i        = LB;
    operand_a_i = '0;
    imm_i       = '0;
    operand_b_i = '0;
    trans_id_i  = '0;
    read_stim();
    if (n_ops == 0) begin
      report_failure("The stimulus file holds no operations");
    end
    stim_loaded = 1'b1;

    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;

    for (int i = 0; i < n_ops; i++) begin
      @(posedge clk_i);
      valid_i     <= 1'b1;
      op_i        <= lsu_op_e'(stim_op[i][3:0]);
      operand_a_i <= stim_a[i];
      imm_i       <= stim_imm[i];
      operand_b_i <= stim_b[i];
      trans_id_i  <= stim_tid[i][TRANS_ID_W-1:0];
      exp_kind_q.push_back(stim_kind[i]);
      exp_tid_q.push_back(stim_tid[i]);
      exp_word_q.push_back(stim_exp[i]);
      repeat (stim_gap[i]) begin
        @(posedge clk_i);
        valid_i <= 1'b0;
      end
    end
    @(posedge clk_i);
    valid_i <= 1'b0;

    wait (n_checked == n_ops);
    // A few idle cycles catch any stray result
    repeat (5) @(posedge clk_i);
    if (error_count == 0 && lsu_top_inst.lsu_assert_inst.fail_count == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      $display("Finished with errors");
      $fatal(1);
    end
  end

endmodule

/* lsu_lite.f */
hw/lsu_pkg.sv
hw/lsu_result_if.sv
hw/lsu_agu.sv
hw/lsu_mem_access.sv
hw/lsu_pipe_stage.sv
hw/lsu_result_split.sv
hw/lsu_top.sv
verif/lsu_assert.sv
verif/lsu_tb.sv

/* Bender.yml */
package:
  name: lsu_lite

sources:
  - files:
      - hw/lsu_pkg.sv
      - hw/lsu_result_if.sv
      - hw/lsu_agu.sv
      - hw/lsu_mem_access.sv
      - hw/lsu_pipe_stage.sv
      - hw/lsu_result_split.sv
      - hw/lsu_top.sv
  - target: test
    files:
      - verif/lsu_assert.sv
      - verif/lsu_tb.sv

/* verif/lsu_stim.txt */
# op a imm b trans_id kind expected gap, all fields hex, gap is idle cycles after the op
# kind 0 load, 1 store, 2 load fault, 3 store fault; expected is load data or {cause, 12'h0, tval}
7 00000010 00000000 11223344 0 1 00000000 1
6 00000010 00000002 0000aabb 1 1 00000000 1
5 00000010 00000001 000000cc 2 1 00000000 1
4 00000010 00000000 00000000 3 0 aabbcc44 1
0 00000013 00000000 00000000 4 0 ffffffaa 1
1 00000013 00000000 00000000 5 0 000000aa 1
2 00000012 00000000 00000000 6 0 ffffaabb 1
3 00000012 00000000 00000000 7 0 0000aabb 1
5 00000040 fffffff8 00000085 0 1 00000000 1
0 0000003c fffffffc 00000000 1 0 ffffff85 1
2 00000021 00000000 00000000 2 2 40000021 1
4 00000022 00000000 00000000 3 2 40000022 1
7 00000010 00000001 deadbeef 4 3 60000011 1
6 00000013 00000000 00001234 5 3 60000013 1
4 00000010 00000000 00000000 6 0 aabbcc44 1
4 00000100 00000000 00000000 7 2 50000100 1
6 000000f0 00000013 00001234 0 3 70000103 1
0 00000000 ffffffff 00000000 1 2 5000ffff 2
7 00000080 00000000 01020304 1 1 00000000 0
4 00000080 00000000 00000000 2 0 01020304 0
5 00000080 00000003 000000f0 3 1 00000000 0
4 00000080 00000000 00000000 4 0 f0020304 0
3 00000080 00000002 00000000 5 0 0000f002 0
2 00000080 00000002 00000000 6 0 fffff002 1
